/* common/alu_settings.svh */
`ifndef ALU_SETTINGS_SVH
`define ALU_SETTINGS_SVH

// ==========================================================================
// Execution unit sizing
// ==========================================================================

// Width of one operand or result word
`define ALU_WIDTH 32

// Width of the divider step counter that counts every quotient bit
`define ALU_DIV_CNT_W 6

`endif

/* common/isa_pkg.sv */
package isa_pkg;

	// Raw instruction word with the opcode in bits 6..0 and the function code in 31..25
	typedef logic [31:0] instruction_t;
	typedef logic [6:0] opcode_t;
	typedef logic [6:0] func_t;

	// Major opcodes handled by the execution unit
	localparam opcode_t OP_R2    = 7'h02;
	localparam opcode_t OP_ADDI  = 7'h04;
	localparam opcode_t OP_MULI  = 7'h06;
	localparam opcode_t OP_MULUI = 7'h07;
	localparam opcode_t OP_DIVI  = 7'h08;
	localparam opcode_t OP_DIVUI = 7'h09;
	localparam opcode_t OP_ANDI  = 7'h0C;
	localparam opcode_t OP_ORI   = 7'h0D;
	localparam opcode_t OP_EORI  = 7'h0E;
	localparam opcode_t OP_SLTI  = 7'h10;
	localparam opcode_t OP_LDO   = 7'h46;
	localparam opcode_t OP_STO   = 7'h53;
	localparam opcode_t OP_LDX   = 7'h48;
	localparam opcode_t OP_STX   = 7'h58;

	// Function codes of the register-register group
	localparam func_t FN_ADD   = 7'h04;
	localparam func_t FN_SUB   = 7'h05;
	localparam func_t FN_AND   = 7'h08;
	localparam func_t FN_OR    = 7'h09;
	localparam func_t FN_EOR   = 7'h0A;
	localparam func_t FN_NAND  = 7'h0C;
	localparam func_t FN_SLT   = 7'h10;
	localparam func_t FN_SLTU  = 7'h11;
	localparam func_t FN_SEQ   = 7'h12;
	localparam func_t FN_MUL   = 7'h18;
	localparam func_t FN_MULU  = 7'h19;
	localparam func_t FN_MULH  = 7'h1A;
	localparam func_t FN_MULUH = 7'h1B;
	localparam func_t FN_DIV   = 7'h20;
	localparam func_t FN_DIVU  = 7'h21;
	localparam func_t FN_MOD   = 7'h22;
	localparam func_t FN_MODU  = 7'h23;

	// Result word returned for any code the unit does not know
	localparam logic [31:0] FILLER_WORD = 32'hDEADBEEF;

endpackage

/* common/alu_pkg.sv */
`include "alu_settings.svh"

package alu_pkg;

	// ======================================================================
	// Datapath value types
	// ======================================================================

	// One operand or result word
	typedef logic [`ALU_WIDTH-1:0] value_t;

	// Full product of two words with the high half on top
	typedef logic [2*`ALU_WIDTH-1:0] double_value_t;

	// Divider sequencing
	// Idle waits for a load, run makes one quotient bit per cycle,
	// fix applies signs and the divide-by-zero result
	typedef enum logic [1:0] {
		DIV_IDLE,
		DIV_RUN,
		DIV_FIX
	} div_state_t;

endpackage

/* common/div_if.sv */
interface div_if;
	import alu_pkg::*;

	// The requester drives ld as a single-cycle pulse that restarts the division
	logic ld;
	logic sgn;
	value_t a;
	value_t b;

	// Results from the divider stay valid while done is high
	value_t q;
	value_t r;
	logic dbz;
	logic done;
	logic idle;

	modport requester (
		output ld, sgn, a, b,
		input q, r, dbz, done, idle
	);

	modport divider (
		input ld, sgn, a, b,
		output q, r, dbz, done, idle
	);
endinterface

/* rtl/change_detect.sv */
`include "alu_settings.svh"

module change_detect (
	input logic clk,
	input logic rst,
	input logic [2*`ALU_WIDTH-1:0] data,
	output logic cd
);
	logic [2*`ALU_WIDTH-1:0] data_q;
	logic armed;

	// Copy of the operand pair as it stood at the last edge
	always_ff @(posedge clk)
		data_q <= data;

	// Armed while in reset so that the first cycle afterwards counts as a change
	always_ff @(posedge clk)
	begin
		if (rst)
			armed <= 1'b1;
		else
			armed <= 1'b0;
	end

	// Any bit differing from the copy flags a new operation
	assign cd = armed | (data != data_q);

endmodule

/* alu/alu_multiplier.sv */
module alu_multiplier (
	input logic clk,
	input logic rst,
	input logic clr,
	input alu_pkg::value_t a,
	input alu_pkg::value_t b,
	output alu_pkg::double_value_t prod,
	output alu_pkg::double_value_t produ,
	output logic done
);
	import alu_pkg::*;

	double_value_t prod_s1;
	double_value_t prod_s2;
	double_value_t produ_s1;
	double_value_t produ_s2;
	logic [3:0] cnt;

	// Three registers per product so a retimer can spread the multiply
	// Each stage simply passes the earlier stage on, so pairs queue behind each other
	always_ff @(posedge clk)
	begin
		prod_s1 <= $signed(a) * $signed(b);
		prod_s2 <= prod_s1;
		prod <= prod_s2;
		produ_s1 <= a * b;
		produ_s2 <= produ_s1;
		produ <= produ_s2;
	end

	// Ones shift in after a clear, and done follows the top bit a cycle later
	// The final stage holds the new pair well before done rises
	always_ff @(posedge clk)
	begin
		if (rst || clr)
		begin
			cnt <= '0;
			done <= 1'b0;
		end
		else
		begin
			cnt <= {cnt[2:0], 1'b1};
			done <= cnt[3];
		end
	end

endmodule

/* alu/alu_divider.sv */
`include "alu_settings.svh"

module alu_divider (
	input logic clk,
	input logic rst,
	div_if.divider dv
);
	import alu_pkg::*;

	div_state_t state;
	logic [`ALU_DIV_CNT_W-1:0] step;
	value_t quo;
	value_t rem;
	value_t dvsr;
	value_t dvnd;
	logic neg_q;
	logic neg_r;
	logic [`ALU_WIDTH:0] shifted;
	logic [`ALU_WIDTH:0] diff;

	// Partial remainder with the next dividend bit brought down, and the trial subtract
	assign shifted = {rem, quo[`ALU_WIDTH-1]};
	assign diff = shifted - {1'b0, dvsr};

	assign dv.idle = (state == DIV_IDLE);

	// ======================================================================
	// Sequencing
	// ======================================================================

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= DIV_IDLE;
			step <= '0;
			dv.done <= 1'b0;
			dv.dbz <= 1'b0;
		end
		else if (dv.ld)
		begin
			// A load restarts from any state
			state <= DIV_RUN;
			step <= '0;
			dv.done <= 1'b0;
			dv.dbz <= 1'b0;
		end
		else
		begin
			case (state)
			DIV_RUN:
			begin
				step <= step + 1'b1;
				// Last quotient bit is produced on this step
				if (step == `ALU_DIV_CNT_W'(`ALU_WIDTH - 1))
					state <= DIV_FIX;
			end
			DIV_FIX:
			begin
				state <= DIV_IDLE;
				dv.done <= 1'b1;
				dv.dbz <= (dvsr == '0);
			end
			default:
				state <= DIV_IDLE;
			endcase
		end
	end

	// ======================================================================
	// Datapath
	// ======================================================================

	always_ff @(posedge clk)
	begin
		if (dv.ld)
		begin
			// Signed mode works on magnitudes and remembers the signs
			quo <= (dv.sgn && dv.a[`ALU_WIDTH-1]) ? -dv.a : dv.a;
			dvsr <= (dv.sgn && dv.b[`ALU_WIDTH-1]) ? -dv.b : dv.b;
			rem <= '0;
			dvnd <= dv.a;
			neg_q <= dv.sgn & (dv.a[`ALU_WIDTH-1] ^ dv.b[`ALU_WIDTH-1]);
			neg_r <= dv.sgn & dv.a[`ALU_WIDTH-1];
		end
		else if (state == DIV_RUN)
		begin
			// Keep the difference only when the divisor fits
			if (!diff[`ALU_WIDTH])
			begin
				rem <= diff[`ALU_WIDTH-1:0];
				quo <= {quo[`ALU_WIDTH-2:0], 1'b1};
			end
			else
			begin
				rem <= shifted[`ALU_WIDTH-1:0];
				quo <= {quo[`ALU_WIDTH-2:0], 1'b0};
			end
		end
		else if (state == DIV_FIX)
		begin
			if (dvsr == '0)
			begin
				// Zero divisor gives all ones and hands back the dividend
				dv.q <= '1;
				dv.r <= dvnd;
			end
			else
			begin
				// The most negative value over minus one comes out unchanged with remainder 0
				dv.q <= neg_q ? -quo : quo;
				dv.r <= neg_r ? -rem : rem;
			end
		end
	end

endmodule

/* alu/alu_result_mux.sv */
`include "alu_settings.svh"

module alu_result_mux (
	input isa_pkg::instruction_t ir,
	input alu_pkg::value_t a,
	input alu_pkg::value_t b,
	input alu_pkg::value_t i,
	input alu_pkg::value_t t,
	input alu_pkg::value_t p,
	input alu_pkg::double_value_t prod,
	input alu_pkg::double_value_t produ,
	input alu_pkg::value_t div_q,
	input alu_pkg::value_t div_r,
	output alu_pkg::value_t o
);
	import isa_pkg::*;
	import alu_pkg::*;

	opcode_t opcode;
	func_t func;
	value_t slt;
	value_t sltu;
	value_t seq;
	value_t bus;

	// Field extraction from the instruction word
	assign opcode = ir[6:0];
	assign func = ir[31:25];

	// Set results are a single 1 or 0 in the low bit
	assign slt = value_t'($signed(a) < $signed(b));
	assign sltu = value_t'(a < b);
	assign seq = value_t'(a == b);

	// ======================================================================
	// Result selection
	// ======================================================================

	always_comb
	begin
		case (opcode)
		OP_R2:
			case (func)
			FN_ADD:   bus = a + b;
			FN_SUB:   bus = a - b;
			FN_AND:   bus = a & b;
			FN_OR:    bus = a | b;
			FN_EOR:   bus = a ^ b;
			FN_NAND:  bus = ~(a & b);
			FN_SLT:   bus = slt;
			FN_SLTU:  bus = sltu;
			FN_SEQ:   bus = seq;
			FN_MUL:   bus = prod[`ALU_WIDTH-1:0];
			FN_MULU:  bus = produ[`ALU_WIDTH-1:0];
			FN_MULH:  bus = prod[2*`ALU_WIDTH-1:`ALU_WIDTH];
			FN_MULUH: bus = produ[2*`ALU_WIDTH-1:`ALU_WIDTH];
			// Sign mode of the divider comes from the div input, not the code
			FN_DIV, FN_DIVU: bus = div_q;
			FN_MOD, FN_MODU: bus = div_r;
			default:  bus = FILLER_WORD;
			endcase
		OP_ADDI:  bus = a + b;
		OP_MULI:  bus = prod[`ALU_WIDTH-1:0];
		OP_MULUI: bus = produ[`ALU_WIDTH-1:0];
		OP_DIVI, OP_DIVUI: bus = div_q;
		OP_ANDI:  bus = a & b;
		OP_ORI:   bus = a | b;
		OP_EORI:  bus = a ^ b;
		OP_SLTI:  bus = slt;
		// Plain load and store address is base plus displacement
		OP_LDO, OP_STO: bus = a + b;
		// Indexed forms add the index register on top
		OP_LDX, OP_STX: bus = a + b + i;
		default:  bus = FILLER_WORD;
		endcase
	end

	// A false predicate keeps the old target value
	assign o = p[0] ? bus : t;

endmodule

/* rtl/alu_unit.sv */
module alu_unit (
	input logic clk,
	input logic rst,
	input isa_pkg::instruction_t ir,
	input logic div,
	input alu_pkg::value_t a,
	input alu_pkg::value_t b,
	input alu_pkg::value_t i,
	input alu_pkg::value_t t,
	input alu_pkg::value_t p,
	output alu_pkg::value_t o,
	output logic mul_done,
	output logic div_done,
	output logic div_dbz
);
	import alu_pkg::*;

	logic cd;
	double_value_t prod;
	double_value_t produ;

	div_if u_div_if ();

	// A new operand pair restarts both long operations
	change_detect u_change_detect (
		.clk(clk),
		.rst(rst),
		.data({a, b}),
		.cd(cd)
	);

	alu_multiplier u_alu_multiplier (
		.clk(clk),
		.rst(rst),
		.clr(cd),
		.a(a),
		.b(b),
		.prod(prod),
		.produ(produ),
		.done(mul_done)
	);

	// ======================================================================
	// Divider request and status
	// ======================================================================

	assign u_div_if.ld = cd;
	assign u_div_if.sgn = div;
	assign u_div_if.a = a;
	assign u_div_if.b = b;

	alu_divider u_alu_divider (
		.clk(clk),
		.rst(rst),
		.dv(u_div_if.divider)
	);

	assign div_done = u_div_if.done;
	assign div_dbz = u_div_if.dbz;

	alu_result_mux u_alu_result_mux (
		.ir(ir),
		.a(a),
		.b(b),
		.i(i),
		.t(t),
		.p(p),
		.prod(prod),
		.produ(produ),
		.div_q(u_div_if.q),
		.div_r(u_div_if.r),
		.o(o)
	);

endmodule

/* verif/tb_clock_gen.sv */
module tb_clock_gen (
	output logic clk,
	output logic rst
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int HALF_PERIOD = 20;
	localparam int RESET_CYCLES = 2;
	localparam int RELEASE_DELAY = 2;

	// Free-running clock with a 40 ns period
	initial
	begin
		clk = 1'b0;
		forever
			#HALF_PERIOD clk = ~clk;
	end

	// Reset covers the first two rising edges and drops just after the second
	initial
	begin
		rst = 1'b1;
		repeat (RESET_CYCLES)
			@(posedge clk);
		#RELEASE_DELAY rst = 1'b0;
	end

endmodule

/* verif/alu_checker.sv */
module alu_checker (
	input logic clk,
	input logic rst,
	input alu_pkg::value_t a,
	input alu_pkg::value_t b,
	input alu_pkg::value_t t,
	input alu_pkg::value_t p,
	input alu_pkg::value_t o,
	input logic mul_done,
	input logic div_done,
	input logic div_dbz
);
	timeunit 1ns;
	timeprecision 100ps;

	// ==========================================================================
	// Protocol properties of the execution unit
	// ==========================================================================

	// Reset clears every completion flag by the following cycle
	done_low_after_reset: assert property (@(posedge clk)
		rst |=> (!mul_done && !div_done && !div_dbz))
		else $error("A done flag is still high in the cycle after reset");

	// A divide-by-zero result is only flagged on a finished division
	dbz_needs_done: assert property (@(posedge clk) disable iff (rst)
		div_dbz |-> div_done)
		else $error("div_dbz is high while div_done is low");

	// A new operand pair clears the multiplier counter on the next edge
	mul_restart: assert property (@(posedge clk) disable iff (rst)
		$changed({a, b}) |=> !mul_done)
		else $error("mul_done stayed high after the operands changed");

	// A false predicate passes the old target value straight through
	predicate_off: assert property (@(posedge clk) disable iff (rst)
		!p[0] |-> (o == t))
		else $error("o differs from t while the predicate bit is clear");

endmodule

// Attach the checker to every instance of the top level
bind alu_unit alu_checker u_alu_checker (
	.clk(clk),
	.rst(rst),
	.a(a),
	.b(b),
	.t(t),
	.p(p),
	.o(o),
	.mul_done(mul_done),
	.div_done(div_done),
	.div_dbz(div_dbz)
);

/* verif/tb_alu_unit.sv */
module tb_alu_unit;
	timeunit 1ns;
	timeprecision 100ps;
	import isa_pkg::*;
	import alu_pkg::*;

	localparam int N_TESTS = 6;
	localparam int N_OPS = 200;
	localparam int OP_CYCLES = 40;
	localparam int CYCLE_LIMIT = N_TESTS * N_OPS * OP_CYCLES;
	localparam int DRIVE_DELAY = 2;
	localparam int SETTLE = 10;
	localparam int MUL_EDGES = 6;
	localparam int DIV_WAIT_MAX = $bits(value_t) + 8;
	localparam logic [31:0] SEED = 32'h0cb6_5e39;

	// Short operations picked at random in the combinational tests
	localparam func_t SHORT_FUNCS [9] = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_EOR,
		FN_NAND, FN_SLT, FN_SLTU, FN_SEQ};
	localparam opcode_t SHORT_OPS [5] = '{OP_ADDI, OP_ANDI, OP_ORI, OP_EORI, OP_SLTI};
	localparam opcode_t ADDR_OPS [4] = '{OP_LDO, OP_STO, OP_LDX, OP_STX};

	// Product reads in the order signed low, unsigned low, signed high, unsigned high,
	// then the two immediate forms
	localparam opcode_t MUL_OPS [6] = '{OP_R2, OP_R2, OP_R2, OP_R2, OP_MULI, OP_MULUI};
	localparam func_t MUL_FUNCS [6] = '{FN_MUL, FN_MULU, FN_MULH, FN_MULUH, FN_ADD, FN_ADD};

	logic clk;
	logic rst;
	instruction_t ir;
	logic div;
	value_t a;
	value_t b;
	value_t i;
	value_t t;
	value_t p;
	value_t o;
	logic mul_done;
	logic div_done;
	logic div_dbz;

	int total_checks;
	int total_errors;
	int test_checks;
	int test_errors;
	int tests_run;
	int cycle_cnt;

	tb_clock_gen u_tb_clock_gen (
		.clk(clk),
		.rst(rst)
	);

	alu_unit u_alu_unit (
		.clk(clk),
		.rst(rst),
		.ir(ir),
		.div(div),
		.a(a),
		.b(b),
		.i(i),
		.t(t),
		.p(p),
		.o(o),
		.mul_done(mul_done),
		.div_done(div_done),
		.div_dbz(div_dbz)
	);

	// ==========================================================================
	// Bookkeeping and helpers
	// ==========================================================================

	task automatic compare_value(input string name, input value_t got, input value_t exp);
		total_checks++;
		test_checks++;
		if (got !== exp)
		begin
			total_errors++;
			test_errors++;
			$display("Error: %s is %h, expected %h", name, got, exp);
		end
	endtask

	task automatic note_failure(input string what);
		total_errors++;
		test_errors++;
		$display("Failure: %s", what);
	endtask

	task automatic report_test(input string name);
		tests_run++;
		$display("[%0d] %s finished, %0d checks, %0d mismatches",
			tests_run, name, test_checks, test_errors);
		test_checks = 0;
		test_errors = 0;
	endtask

	// Inputs change a fixed delay after the rising edge
	task automatic step_to_drive();
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	function automatic instruction_t make_ir(input opcode_t op, input func_t fn);
		instruction_t w;
		w = $urandom;
		w[6:0] = op;
		w[31:25] = fn;
		return w;
	endfunction

	// Counts edges after a drive until the chosen done flag is seen high
	task automatic wait_done(input bit for_div, output int edges);
		bit seen;
		int limit;
		limit = for_div ? DIV_WAIT_MAX : 2 * MUL_EDGES;
		edges = 0;
		seen = 1'b0;
		while (!seen && edges < limit)
		begin
			@(posedge clk);
			edges++;
			#1;
			seen = for_div ? div_done : mul_done;
		end
		if (!seen)
			note_failure($sformatf("%s never rose within %0d cycles",
				for_div ? "div_done" : "mul_done", limit));
	endtask

	// Reference for the single-cycle operations and address sums
	function automatic value_t model_short(input opcode_t op, input func_t fn,
		input value_t x, input value_t y, input value_t z);
		case (op)
		OP_R2:
			case (fn)
			FN_ADD:  return x + y;
			FN_SUB:  return x - y;
			FN_AND:  return x & y;
			FN_OR:   return x | y;
			FN_EOR:  return x ^ y;
			FN_NAND: return ~(x & y);
			FN_SLT:  return ($signed(x) < $signed(y)) ? value_t'(1) : value_t'(0);
			FN_SLTU: return (x < y) ? value_t'(1) : value_t'(0);
			FN_SEQ:  return (x == y) ? value_t'(1) : value_t'(0);
			default: return FILLER_WORD;
			endcase
		OP_ADDI, OP_LDO, OP_STO: return x + y;
		OP_LDX, OP_STX: return x + y + z;
		OP_ANDI: return x & y;
		OP_ORI:  return x | y;
		OP_EORI: return x ^ y;
		OP_SLTI: return ($signed(x) < $signed(y)) ? value_t'(1) : value_t'(0);
		default: return FILLER_WORD;
		endcase
	endfunction

	// Mostly known codes with an undefined opcode or function code now and then
	task automatic pick_short(output opcode_t op, output func_t fn);
		int r;
		r = $urandom_range(0, 15);
		fn = func_t'($urandom);
		if (r < 8)
		begin
			op = OP_R2;
			fn = SHORT_FUNCS[$urandom_range(0, 8)];
		end
		else if (r < 13)
			op = SHORT_OPS[$urandom_range(0, 4)];
		else if (r == 13)
		begin
			op = OP_R2;
			fn = 7'h40 | 7'($urandom_range(0, 63));
		end
		else
			op = 7'h60 | 7'($urandom_range(0, 31));
	endtask

	// ==========================================================================
	// Tests
	// ==========================================================================

	task automatic run_short_ops(input bit pred_on);
		opcode_t op;
		func_t fn;
		value_t exp;
		for (int k = 0; k < N_OPS; k++)
		begin
			pick_short(op, fn);
			step_to_drive();
			ir = make_ir(op, fn);
			a = $urandom;
			b = $urandom;
			i = $urandom;
			t = $urandom;
			p = pred_on ? ($urandom | 32'd1) : ($urandom & ~32'd1);
			exp = pred_on ? model_short(op, fn, a, b, i) : t;
			#SETTLE;
			compare_value("o", o, exp);
		end
	endtask

	task automatic check_addresses();
		opcode_t op;
		for (int k = 0; k < N_OPS; k++)
		begin
			op = ADDR_OPS[$urandom_range(0, 3)];
			step_to_drive();
			ir = make_ir(op, func_t'($urandom));
			a = $urandom;
			b = $urandom;
			i = $urandom;
			p = $urandom | 32'd1;
			#SETTLE;
			compare_value("o", o, model_short(op, FN_ADD, a, b, i));
		end
	endtask

	task automatic multiply_pairs();
		longint sa;
		longint sb;
		double_value_t ps;
		double_value_t pu;
		value_t exp [6];
		int edges;
		for (int k = 0; k < N_OPS; k++)
		begin
			step_to_drive();
			a = $urandom;
			b = $urandom;
			ir = make_ir(OP_R2, FN_MUL);
			p = $urandom | 32'd1;
			sa = longint'($signed(a));
			sb = longint'($signed(b));
			ps = double_value_t'(sa * sb);
			pu = double_value_t'(a) * double_value_t'(b);
			exp = '{ps[31:0], pu[31:0], ps[63:32], pu[63:32], ps[31:0], pu[31:0]};
			wait_done(1'b0, edges);
			if (edges != MUL_EDGES)
				note_failure($sformatf("mul_done rose after %0d edges instead of %0d",
					edges, MUL_EDGES));
			for (int r = 0; r < 6; r++)
			begin
				step_to_drive();
				ir = make_ir(MUL_OPS[r], MUL_FUNCS[r]);
				#SETTLE;
				compare_value("o", o, exp[r]);
			end
		end
	endtask

	// Runs one division and reads the quotient and the remainder through o
	task automatic divide_once(input bit sgn, input value_t x, input value_t y);
		longint sx;
		longint sy;
		value_t eq;
		value_t er;
		int edges;
		if (y == '0)
		begin
			eq = '1;
			er = x;
		end
		else if (sgn)
		begin
			sx = longint'($signed(x));
			sy = longint'($signed(y));
			eq = value_t'(sx / sy);
			er = value_t'(sx % sy);
		end
		else
		begin
			eq = x / y;
			er = x % y;
		end
		step_to_drive();
		a = x;
		b = y;
		div = sgn;
		ir = make_ir(OP_R2, sgn ? FN_DIV : FN_DIVU);
		p = $urandom | 32'd1;
		wait_done(1'b1, edges);
		compare_value("div_dbz", value_t'(div_dbz), value_t'(y == '0));
		compare_value("o", o, eq);
		step_to_drive();
		ir = make_ir(OP_R2, sgn ? FN_MOD : FN_MODU);
		#SETTLE;
		compare_value("o", o, er);
	endtask

	task automatic divide_pairs();
		value_t y;
		// Overflow corner of signed division
		divide_once(1'b1, 32'h8000_0000, 32'hFFFF_FFFF);
		for (int k = 0; k < N_OPS; k++)
		begin
			y = $urandom;
			if ($urandom_range(0, 1))
				y = y >> $urandom_range(1, 31);
			if (y == '0)
				y = 32'd1;
			divide_once(1'($urandom_range(0, 1)), $urandom, y);
		end
	endtask

	task automatic divide_by_zero();
		for (int k = 0; k < N_OPS / 4; k++)
			divide_once(1'($urandom_range(0, 1)), $urandom, '0);
	endtask

	// Predicate clear on random operations, then while a division is pending
	task automatic predicate_off();
		run_short_ops(1'b0);
		for (int k = 0; k < N_OPS / 20; k++)
		begin
			step_to_drive();
			a = $urandom;
			b = $urandom | 32'd1;
			div = 1'b0;
			ir = make_ir(OP_DIVUI, FN_DIVU);
			t = $urandom;
			p = $urandom & ~32'd1;
			for (int c = 0; c < N_OPS / 10; c++)
			begin
				step_to_drive();
				// Reading the busy divider must still give back the old target
				if ($urandom_range(0, 1))
					ir = make_ir(OP_DIVUI, FN_DIVU);
				else
					ir = make_ir(OP_R2, SHORT_FUNCS[$urandom_range(0, 8)]);
				t = $urandom;
				#SETTLE;
				compare_value("o", o, t);
				compare_value("div_done", value_t'(div_done), '0);
			end
		end
	endtask

	// ==========================================================================
	// Run control
	// ==========================================================================

	initial
	begin
		cycle_cnt = 0;
		while (cycle_cnt < CYCLE_LIMIT)
		begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("Timeout: the run did not end within %0d clock cycles", CYCLE_LIMIT);
		$display("test failed");
		$finish;
	end

	initial
	begin
		void'($urandom(SEED));
		ir = '0;
		div = 1'b0;
		a = '0;
		b = '0;
		i = '0;
		t = '0;
		p = 32'd1;
		total_checks = 0;
		total_errors = 0;
		test_checks = 0;
		test_errors = 0;
		tests_run = 0;
		while (rst !== 1'b0)
			@(posedge clk);

		run_short_ops(1'b1);
		report_test("combinational operations");
		check_addresses();
		report_test("address sums");
		multiply_pairs();
		report_test("multiply");
		divide_pairs();
		report_test("divide and modulo");
		divide_by_zero();
		report_test("divide by zero");
		predicate_off();
		report_test("predication");

		$display("Summary: %0d tests, %0d checks, %0d errors",
			tests_run, total_checks, total_errors);
		if (total_errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

/* compile.f */
+incdir+common
common/isa_pkg.sv
common/alu_pkg.sv
common/div_if.sv
rtl/change_detect.sv
alu/alu_multiplier.sv
alu/alu_divider.sv
alu/alu_result_mux.sv
rtl/alu_unit.sv
verif/tb_clock_gen.sv
verif/alu_checker.sv
verif/tb_alu_unit.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f compile.f --top-module tb_alu_unit -o sim_alu_unit

./obj_dir/sim_alu_unit | tee sim.log

if grep -q "test failed" sim.log; then
	exit 1
fi
